/* project.f */
verilog/pm_pkg.sv
verilog/pm_input_sync.sv
verilog/pm_state_machine.sv
verilog/pm_event_counters.sv
verilog/pm_axil_regs.sv
verilog/pm_unit_top.sv
tb/pm_unit_props.sv
tb/pm_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the power management unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f project.f \
  --top-module pm_unit_tb \
  -o pm_unit_sim

./obj_dir/pm_unit_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb/pm_unit_props.sv */
// Concurrent checks on the power management state machine
// Shields and gate request per state, exact quiesce length in IF_OFF
`timescale 1ns/10ps
`default_nettype none

module pm_unit_props #(
  parameter int QUIESCE_CYCLES = 32
) (
  input wire logic               prim_freerun_clk,
  input wire logic               prim_freerun_prim_gated_rst_b_sync,
  input wire pm_pkg::pm_status_t status
);

  import pm_pkg::*;

  logic in_if_off;
  int   if_off_cnt;  // Cycles already spent in IF_OFF

  assign in_if_off = (status.state == PMSM_IF_OFF);

  always_ff @(posedge prim_freerun_clk or negedge prim_freerun_prim_gated_rst_b_sync) begin
    if (!prim_freerun_prim_gated_rst_b_sync) if_off_cnt <= 0;
    else if (in_if_off) if_off_cnt <= if_off_cnt + 1;
    else if_off_cnt <= 0;
  end

  shields_outside_run: assert property (@(posedge prim_freerun_clk)
    disable iff (!prim_freerun_prim_gated_rst_b_sync)
    status.shields_up == (status.state != PMSM_RUN))
    else $error("shields_up does not follow the RUN state");

  req_low_when_gating: assert property (@(posedge prim_freerun_clk)
    disable iff (!prim_freerun_prim_gated_rst_b_sync)
    !status.pgcb_req_b |-> (status.state == PMSM_WAIT_ACK || status.state == PMSM_PWR_OFF))
    else $error("pgcb_req_b low outside WAIT_ACK and PWR_OFF");

  // Quiesce is QUIESCE_CYCLES+1 cycles, then straight to WAIT_ACK
  quiesce_holds: assert property (@(posedge prim_freerun_clk)
    disable iff (!prim_freerun_prim_gated_rst_b_sync)
    (in_if_off && if_off_cnt < QUIESCE_CYCLES) |=> in_if_off)
    else $error("IF_OFF left early");

  quiesce_exits: assert property (@(posedge prim_freerun_clk)
    disable iff (!prim_freerun_prim_gated_rst_b_sync)
    (in_if_off && if_off_cnt == QUIESCE_CYCLES) |=> (status.state == PMSM_WAIT_ACK))
    else $error("IF_OFF not followed by WAIT_ACK on time");

endmodule

bind pm_state_machine pm_unit_props #(.QUIESCE_CYCLES(QUIESCE_CYCLES)) u_props (
  .prim_freerun_clk                   (prim_freerun_clk),
  .prim_freerun_prim_gated_rst_b_sync (prim_freerun_prim_gated_rst_b_sync),
  .status                             (status)
);

`default_nettype wire

/* tb/pm_unit_tb.sv */
// Testbench for the power management unit
// Drives AXI4-Lite, fuses, D3 and force-on, models the power gate
// controller and compares settled states with a reference model
`timescale 1ns/10ps
`default_nettype none

module pm_unit_tb;

  import pm_pkg::*;

  localparam int         QUIESCE_CYCLES = 16;
  localparam int         WAIT_LIMIT     = 200;  // Cycles per wait loop
  localparam logic [1:0] RESP_OKAY      = 2'b00;
  localparam logic [1:0] RESP_SLVERR    = 2'b10;

  logic      prim_freerun_clk                   = 1'b0;
  logic      prim_freerun_prim_gated_rst_b_sync = 1'b0;
  axil_req_t axil_req       = '0;
  axil_rsp_t axil_rsp;
  pm_fuse_t  fuse           = '0;
  logic      in_d3          = 1'b0;
  logic      hw_force_on    = 1'b0;
  logic      pgcb_idle      = 1'b0;
  logic      pgcb_rdy_ack_b = 1'b0;  // Partition starts gated
  logic      pgcb_req_b, shields_up, d0tod3_ok, d3tod0_ok, pm_active, run_entry;
  int        n_checks = 0;
  int        n_errors = 0;
  int        run_entry_seen = 0;
  logic      req_b_seen = 1'b0;  // Mid-cycle copy of the request
  int        gate_wait = 0;

  pm_unit_top #(.QUIESCE_CYCLES(QUIESCE_CYCLES)) u_pm_unit_top (.*);

  always #2 prim_freerun_clk = ~prim_freerun_clk;  // 4 ns period

  // --------------------
  // Power gate controller model
  // --------------------
  always @(negedge prim_freerun_clk) begin
    req_b_seen <= pgcb_req_b;
    if (prim_freerun_prim_gated_rst_b_sync && run_entry) run_entry_seen++;
  end

  always @(posedge prim_freerun_clk) begin
    if (req_b_seen == pgcb_rdy_ack_b) gate_wait <= 0;  // Nothing pending
    else if (gate_wait == 0) gate_wait <= int'($urandom_range(8, 1));
    else if (gate_wait == 1) begin
      pgcb_rdy_ack_b <= req_b_seen;  // Ack low gated, high ready
      pgcb_idle      <= req_b_seen;
      gate_wait      <= 0;
    end else gate_wait <= gate_wait - 1;
  end

  // --------------------
  // Checks and bus tasks
  // --------------------
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp)
      else begin
        $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        n_errors++;
      end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s did not happen in time", $time, what);
    n_errors++;
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    @(posedge prim_freerun_clk);
    axil_req.aw_valid <= 1'b1;
    axil_req.aw_addr  <= addr;
    axil_req.w_valid  <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= 4'hF;
    axil_req.b_ready  <= 1'b1;
    n = 0;
    do begin
      @(negedge prim_freerun_clk);
      n++;
    end while (!axil_rsp.aw_ready && n < WAIT_LIMIT);
    assert (axil_rsp.aw_ready) else report_timeout("write address accept");
    @(posedge prim_freerun_clk);  // Accept edge
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    n = 0;
    do begin
      @(negedge prim_freerun_clk);
      n++;
    end while (!axil_rsp.b_valid && n < WAIT_LIMIT);
    assert (axil_rsp.b_valid) else report_timeout("write response");
    resp = axil_rsp.b_resp;
    @(posedge prim_freerun_clk);
    axil_req.b_ready <= 1'b0;
  endtask

  // Hold stalls r_ready for that many cycles after r_valid
  task automatic axil_read(input logic [3:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    int n;
    @(posedge prim_freerun_clk);
    axil_req.ar_valid <= 1'b1;
    axil_req.ar_addr  <= addr;
    axil_req.r_ready  <= (hold == 0);
    n = 0;
    do begin
      @(negedge prim_freerun_clk);
      n++;
    end while (!axil_rsp.ar_ready && n < WAIT_LIMIT);
    assert (axil_rsp.ar_ready) else report_timeout("read address accept");
    @(posedge prim_freerun_clk);
    axil_req.ar_valid <= 1'b0;
    n = 0;
    do begin
      @(negedge prim_freerun_clk);
      n++;
    end while (!axil_rsp.r_valid && n < WAIT_LIMIT);
    assert (axil_rsp.r_valid) else report_timeout("read response");
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    repeat (hold) begin
      @(negedge prim_freerun_clk);
      n_checks++;
      assert (axil_rsp.r_valid)
        else begin
          $display("At %0t ns r_valid dropped while r_ready was held low", $time);
          n_errors++;
        end
      check_value("r_data under back-pressure", axil_rsp.r_data, data);
    end
    if (hold > 0) begin
      @(posedge prim_freerun_clk);
      axil_req.r_ready <= 1'b1;
    end
    @(posedge prim_freerun_clk);
    axil_req.r_ready <= 1'b0;
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Resting state for a set of inputs under the go-off/go-on priority
  function automatic pmsm_state_t ref_power_state(pm_fuse_t f, pm_cfg_t c, logic d3, logic hw);
    logic off;
    logic on;
    if (hw) begin  // Force-on input wins
      off = 1'b0;
      on  = 1'b1;
    end else begin
      off = f.proc_disable || (c.pmcsr_disable && (!f.force_on || c.pm_override));
      on  = !off && (c.pm_override || f.force_on);
    end
    if (!off && (!d3 || on)) return PMSM_RUN;
    return PMSM_PWR_OFF;
  endfunction

  task automatic compare_settled_state(input pmsm_state_t exp, input string what);
    logic [31:0] rd;
    logic [1:0]  resp;
    pm_status_t  st;
    int          n;
    n = 0;
    do begin
      axil_read(REG_STATUS, 0, rd, resp);
      st = pm_status_t'(rd[7:0]);
      n++;
    end while (st.state != exp && n < WAIT_LIMIT / 4);
    assert (st.state == exp) else report_timeout({what, " settling"});
    repeat (QUIESCE_CYCLES + 30) @(posedge prim_freerun_clk);  // Must stay there
    axil_read(REG_STATUS, 0, rd, resp);
    st = pm_status_t'(rd[7:0]);
    check_value({what, " status.state"}, 32'(st.state), 32'(exp));
  endtask

  task automatic apply_and_compare(input pm_fuse_t f, input pm_cfg_t c, input logic d3,
                                   input logic hw);
    logic [1:0] resp;
    @(posedge prim_freerun_clk);
    fuse        <= f;
    in_d3       <= d3;
    hw_force_on <= hw;
    axil_write(REG_CTRL, {30'd0, c}, resp);
    compare_settled_state(ref_power_state(f, c, d3, hw),
                          $sformatf("fuse=%b cfg=%b d3=%b hw=%b", f, c, d3, hw));
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("Test %s: %s", name, (n_errors == errs_before) ? "ok" : "failed");
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] run_a;
    logic [31:0] rnd;
    logic [1:0]  resp;
    pm_status_t  st;
    int          errs;
    int          n;
    int          quiesce_len;
    void'($urandom(61));
    repeat (16) @(posedge prim_freerun_clk);
    prim_freerun_prim_gated_rst_b_sync <= 1'b1;

    errs = n_errors;  // Reset values
    @(negedge prim_freerun_clk);
    check_value("pgcb_req_b", 32'(pgcb_req_b), 32'd0);
    check_value("shields_up", 32'(shields_up), 32'd1);
    check_value("d3tod0_ok", 32'(d3tod0_ok), 32'd1);
    check_value("d0tod3_ok", 32'(d0tod3_ok), 32'd0);
    check_value("pm_active", 32'(pm_active), 32'd0);
    check_value("run_entry", 32'(run_entry), 32'd0);
    check_value("b_valid", 32'(axil_rsp.b_valid), 32'd0);
    check_value("r_valid", 32'(axil_rsp.r_valid), 32'd0);
    axil_read(REG_CTRL, 0, rd, resp);
    check_value("REG_CTRL", rd, 32'(PM_CTRL_RESET));
    axil_read(REG_STATUS, 0, rd, resp);
    st = pm_status_t'(rd[7:0]);
    check_value("status.state", 32'(st.state), 32'(PMSM_PWR_OFF));
    check_value("status.shields_up", 32'(st.shields_up), 32'd1);
    check_value("status.pgcb_req_b", 32'(st.pgcb_req_b), 32'd0);
    check_value("status.d3tod0_ok", 32'(st.d3tod0_ok), 32'd1);
    check_value("status.d0tod3_ok", 32'(st.d0tod3_ok), 32'd0);
    axil_read(REG_EVT_CNT, 0, rd, resp);
    check_value("REG_EVT_CNT", rd, 32'd0);
    axil_read(REG_RUN_CNT, 0, rd, resp);
    check_value("REG_RUN_CNT", rd, 32'd0);
    end_test("1 reset values", errs);

    errs = n_errors;  // Power up by override
    run_entry_seen = 0;
    axil_write(REG_CTRL, 32'h2, resp);
    compare_settled_state(PMSM_RUN, "power up");
    check_value("run_entry pulses", 32'(run_entry_seen), 32'd1);
    axil_read(REG_EVT_CNT, 0, rd, resp);
    check_value("REG_EVT_CNT", rd, 32'd1);
    axil_read(REG_RUN_CNT, 4, run_a, resp);  // Counter moves while the read stalls
    repeat (10) @(posedge prim_freerun_clk);
    axil_read(REG_RUN_CNT, 0, rd, resp);
    n_checks++;
    assert (rd > run_a)
      else begin
        $display("Error at %0t ns: REG_RUN_CNT is 0x%0h, expected above 0x%0h", $time, rd, run_a);
        n_errors++;
      end
    end_test("2 power up", errs);

    errs = n_errors;  // Power down with quiesce length at the ports
    fork
      axil_write(REG_CTRL, 32'h1, resp);
      begin
        n = 0;
        do begin
          @(negedge prim_freerun_clk);
          n++;
        end while (!shields_up && n < WAIT_LIMIT);
        assert (shields_up) else report_timeout("shields rising at power down");
        quiesce_len = 0;
        while (shields_up && pgcb_req_b && quiesce_len < WAIT_LIMIT) begin
          quiesce_len++;
          @(negedge prim_freerun_clk);
        end
        check_value("IF_OFF cycles", 32'(quiesce_len), 32'(QUIESCE_CYCLES + 1));
        n = 0;
        while (pm_active && n < WAIT_LIMIT) begin  // WAIT_ACK until the ack
          n++;
          @(negedge prim_freerun_clk);
        end
        assert (!pm_active) else report_timeout("PWR_OFF entry after request");
        check_value("pgcb_rdy_ack_b at PWR_OFF", 32'(pgcb_rdy_ack_b), 32'd0);
      end
    join
    compare_settled_state(PMSM_PWR_OFF, "power down");
    @(negedge prim_freerun_clk);
    check_value("pgcb_req_b", 32'(pgcb_req_b), 32'd0);
    end_test("3 power down", errs);

    errs = n_errors;  // Priority of fuses, config, D3 and force-on
    apply_and_compare(pm_fuse_t'(2'b01), pm_cfg_t'(2'b10), 1'b0, 1'b0);
    apply_and_compare('0, '0, 1'b0, 1'b0);  // Unforced power up waits for idle and ready
    apply_and_compare(pm_fuse_t'(2'b01), pm_cfg_t'(2'b10), 1'b0, 1'b1);
    for (int i = 0; i < 12; i++) begin
      rnd = $urandom();
      apply_and_compare(pm_fuse_t'(rnd[1:0]), pm_cfg_t'(rnd[3:2]), rnd[4], rnd[5]);
    end
    apply_and_compare('0, PM_CTRL_RESET, 1'b0, 1'b0);  // Park gated
    end_test("4 priority", errs);

    errs = n_errors;  // Register protocol
    axil_read(4'h2, 0, rd, resp);
    check_value("unmapped r_resp", 32'(resp), 32'(RESP_SLVERR));
    check_value("unmapped r_data", rd, 32'd0);
    axil_write(REG_STATUS, 32'hFF, resp);
    check_value("REG_STATUS b_resp", 32'(resp), 32'(RESP_SLVERR));
    axil_write(REG_EVT_CNT, 32'd0, resp);
    check_value("REG_EVT_CNT b_resp", 32'(resp), 32'(RESP_OKAY));
    axil_write(REG_RUN_CNT, 32'd0, resp);
    axil_read(REG_EVT_CNT, 0, rd, resp);
    check_value("REG_EVT_CNT after clear", rd, 32'd0);
    axil_read(REG_RUN_CNT, 0, rd, resp);
    check_value("REG_RUN_CNT after clear", rd, 32'd0);
    axil_read(REG_CTRL, 6, rd, resp);
    check_value("REG_CTRL stalled read", rd, 32'(PM_CTRL_RESET));
    check_value("REG_CTRL r_resp", 32'(resp), 32'(RESP_OKAY));
    end_test("5 register protocol", errs);

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/pm_axil_regs.sv */
// AXI4-Lite register block for the power management unit
// Control register (disable, override), status readback and the two
// event counters, where a counter write clears the counter
`timescale 1ns/10ps
`default_nettype none

module pm_axil_regs #(
  parameter int CNT_WIDTH = 16
) (
  input  wire logic               prim_freerun_clk,
  input  wire logic               prim_freerun_prim_gated_rst_b_sync,
  input  wire pm_pkg::axil_req_t  axil_req,
  output pm_pkg::axil_rsp_t       axil_rsp,
  input  wire pm_pkg::pm_status_t status,
  input  wire pm_pkg::pm_counts_t counts,
  output pm_pkg::pm_cfg_t         cfg,
  output logic                    clr_evt,
  output logic                    clr_run
);

  import pm_pkg::*;

  pm_cfg_t      cfg_q;
  pm_reg_addr_t wr_addr, rd_addr;
  logic         wr_accept, rd_accept;
  logic         wr_ctrl;
  logic [1:0]   wr_resp, rd_resp;
  logic [31:0]  rd_data;
  logic         b_valid_q, r_valid_q;
  logic [1:0]   b_resp_q, r_resp_q;
  logic [31:0]  r_data_q;

  assign wr_addr = pm_reg_addr_t'(axil_req.aw_addr);
  assign rd_addr = pm_reg_addr_t'(axil_req.ar_addr);

  // --------------------
  // Write channel
  // --------------------
  // Address and data accepted together, one outstanding response
  assign wr_accept = axil_req.aw_valid & axil_req.w_valid & ~b_valid_q;

  always_comb begin
    wr_ctrl = 1'b0;
    clr_evt = 1'b0;
    clr_run = 1'b0;
    wr_resp = AXI_RESP_OKAY;
    case (wr_addr)
      REG_CTRL:    wr_ctrl = wr_accept & axil_req.w_strb[0];
      REG_STATUS:  wr_resp = AXI_RESP_SLVERR;  // Read only
      REG_EVT_CNT: clr_evt = wr_accept;
      REG_RUN_CNT: clr_run = wr_accept;
      default:     wr_resp = AXI_RESP_SLVERR;  // Unmapped
    endcase
  end

  // --------------------
  // Read channel
  // --------------------
  assign rd_accept = axil_req.ar_valid & ~r_valid_q;

  always_comb begin
    rd_data = '0;
    rd_resp = AXI_RESP_OKAY;
    case (rd_addr)
      REG_CTRL:    rd_data[1:0]           = cfg_q;
      REG_STATUS:  rd_data[7:0]           = status;
      REG_EVT_CNT: rd_data[CNT_WIDTH-1:0] = counts.evt_cnt[CNT_WIDTH-1:0];
      REG_RUN_CNT: rd_data[CNT_WIDTH-1:0] = counts.run_cnt[CNT_WIDTH-1:0];
      default:     rd_resp                = AXI_RESP_SLVERR;  // Reads as zero
    endcase
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge prim_freerun_clk or negedge prim_freerun_prim_gated_rst_b_sync) begin
    if (!prim_freerun_prim_gated_rst_b_sync) begin
      cfg_q     <= PM_CTRL_RESET;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_ctrl) cfg_q <= pm_cfg_t'(axil_req.w_data[1:0]);
      if (wr_accept) b_valid_q <= 1'b1;
      else if (axil_req.b_ready) b_valid_q <= 1'b0;  // Held until taken
      if (rd_accept) r_valid_q <= 1'b1;
      else if (axil_req.r_ready) r_valid_q <= 1'b0;
    end
  end

  // Response payload, captured at acceptance
  always_ff @(posedge prim_freerun_clk) begin
    if (wr_accept) b_resp_q <= wr_resp;
    if (rd_accept) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp.aw_ready = wr_accept;
    axil_rsp.w_ready  = wr_accept;
    axil_rsp.b_valid  = b_valid_q;
    axil_rsp.b_resp   = b_resp_q;
    axil_rsp.ar_ready = rd_accept;
    axil_rsp.r_valid  = r_valid_q;
    axil_rsp.r_data   = r_data_q;
    axil_rsp.r_resp   = r_resp_q;
  end

  assign cfg = cfg_q;  // Straight from the flops

endmodule

`default_nettype wire

/* verilog/pm_event_counters.sv */
// Power management event counters
// Counts power-up events and cycles spent in run, both saturating,
// each cleared by its own pulse from the register block
`timescale 1ns/10ps
`default_nettype none

module pm_event_counters #(
  parameter int CNT_WIDTH = 16
) (
  input  wire logic               prim_freerun_clk,
  input  wire logic               prim_freerun_prim_gated_rst_b_sync,
  input  wire pm_pkg::pm_status_t status,
  input  wire logic               run_entry,
  input  wire logic               clr_evt,
  input  wire logic               clr_run,
  output pm_pkg::pm_counts_t      counts
);

  import pm_pkg::*;

  logic [CNT_WIDTH-1:0] evt_q;  // Power-up events
  logic [CNT_WIDTH-1:0] run_q;  // Cycles in RUN
  logic                 in_run;

  assign in_run = (status.state == PMSM_RUN);

  always_ff @(posedge prim_freerun_clk or negedge prim_freerun_prim_gated_rst_b_sync) begin
    if (!prim_freerun_prim_gated_rst_b_sync) begin
      evt_q <= '0;
      run_q <= '0;
    end else begin
      if (clr_evt) evt_q <= '0;  // Clear wins over increment
      else if (run_entry && !(&evt_q)) evt_q <= evt_q + 1'b1;

      if (clr_run) run_q <= '0;
      else if (in_run && !(&run_q)) run_q <= run_q + 1'b1;  // Sticks at all ones
    end
  end

  // Zero-extend into the fixed-width struct
  always_comb begin
    counts                          = '0;
    counts.evt_cnt[CNT_WIDTH-1:0]   = evt_q;
    counts.run_cnt[CNT_WIDTH-1:0]   = run_q;
  end

endmodule

`default_nettype wire

/* verilog/pm_input_sync.sv */
// Input synchronizer for asynchronous power gate controller signals
// Each bit runs through SYNC_STAGES flops that reset to its own value
`timescale 1ns/10ps
`default_nettype none

module pm_input_sync #(
  parameter int               WIDTH       = 2,
  parameter int               SYNC_STAGES = 2,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  wire logic             prim_freerun_clk,
  input  wire logic             prim_freerun_prim_gated_rst_b_sync,
  input  wire logic [WIDTH-1:0] async_in,
  output logic      [WIDTH-1:0] sync_out
);

  logic [SYNC_STAGES-1:0][WIDTH-1:0] sync_q;  // Stage 0 is the metastable flop

  always_ff @(posedge prim_freerun_clk or negedge prim_freerun_prim_gated_rst_b_sync) begin
    if (!prim_freerun_prim_gated_rst_b_sync) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= RESET_VALUE;  // Inactive level per bit
      end
    end else begin
      sync_q[0] <= async_in;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign sync_out = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

/* verilog/pm_pkg.sv */
// Power management unit shared definitions
// State and register address encodings, AXI4-Lite request and response
// bundles, fuse/config/status/count structs and control register reset value
`default_nettype none

package pm_pkg;

  // --------------------
  // Encodings
  // --------------------
  typedef enum logic [2:0] {
    PMSM_RUN      = 3'd0,  // Partition powered, shields down
    PMSM_IF_OFF   = 3'd1,  // Quiesce before gating
    PMSM_WAIT_ACK = 3'd2,  // Gate request out, waiting on controller
    PMSM_PWR_OFF  = 3'd3,
    PMSM_PWR_ON   = 3'd4   // Waiting on idle and ready
  } pmsm_state_t;

  typedef enum logic [3:0] {
    REG_CTRL    = 4'h0,
    REG_STATUS  = 4'h4,  // Read only
    REG_EVT_CNT = 4'h8,  // Write clears
    REG_RUN_CNT = 4'hC   // Write clears
  } pm_reg_addr_t;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  localparam int PM_CNT_W = 16;  // Widest counter the status struct carries

  // --------------------
  // Bundles
  // --------------------
  typedef struct packed {
    logic        aw_valid;
    logic [3:0]  aw_addr;
    logic        w_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        b_ready;
    logic        ar_valid;
    logic [3:0]  ar_addr;
    logic        r_ready;
  } axil_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic force_on;
    logic proc_disable;
  } pm_fuse_t;

  // Bit 1 override, bit 0 disable, same as REG_CTRL layout
  typedef struct packed {
    logic pm_override;
    logic pmcsr_disable;
  } pm_cfg_t;

  typedef struct packed {
    pmsm_state_t state;
    logic        shields_up;
    logic        pgcb_req_b;
    logic        d3tod0_ok;
    logic        d0tod3_ok;
    logic        idle_sync;
  } pm_status_t;

  typedef struct packed {
    logic [PM_CNT_W-1:0] evt_cnt;
    logic [PM_CNT_W-1:0] run_cnt;
  } pm_counts_t;

  // Partition comes up disabled until software clears the bit
  localparam pm_cfg_t PM_CTRL_RESET = '{pm_override: 1'b0, pmcsr_disable: 1'b1};

endpackage

`default_nettype wire

/* verilog/pm_state_machine.sv */
// Power management state machine
// Decides go-on/go-off from fuses, config, D3 and hardware force-on,
// quiesces behind the shields, then handshakes power gating with the
// external power gate controller
`timescale 1ns/10ps
`default_nettype none

module pm_state_machine #(
  parameter int QUIESCE_CYCLES = 32
) (
  input  wire logic              prim_freerun_clk,
  input  wire logic              prim_freerun_prim_gated_rst_b_sync,
  input  wire pm_pkg::pm_fuse_t  fuse,
  input  wire pm_pkg::pm_cfg_t   cfg,
  input  wire logic              in_d3,
  input  wire logic              hw_force_on,
  input  wire logic              idle_sync,
  input  wire logic              rdy_ack_b_sync,
  output pm_pkg::pm_status_t     status,
  output logic                   run_entry,
  output logic                   pm_active
);

  import pm_pkg::*;

  localparam int                QCNT_W    = $clog2(QUIESCE_CYCLES + 2);
  localparam logic [QCNT_W-1:0] QCNT_LAST = QCNT_W'(QUIESCE_CYCLES);

  pmsm_state_t       state_q, state_nxt;
  logic [QCNT_W-1:0] qcnt_q, qcnt_nxt;  // Quiesce cycle count
  logic              go_off;
  logic              go_on;
  logic              shields_up, pgcb_req_b, d3tod0_ok, d0tod3_ok;

  // --------------------
  // Power decision
  // --------------------
  // Force-on input beats everything
  assign go_off = ~hw_force_on &
                  (fuse.proc_disable | (cfg.pmcsr_disable & (~fuse.force_on | cfg.pm_override)));
  assign go_on  = hw_force_on | ((cfg.pm_override | fuse.force_on) & ~go_off);

  // --------------------
  // Next state, outputs
  // --------------------
  always_comb begin
    state_nxt  = state_q;
    qcnt_nxt   = '0;
    shields_up = 1'b1;  // Safe defaults
    pgcb_req_b = 1'b1;
    d3tod0_ok  = 1'b0;
    d0tod3_ok  = 1'b0;
    case (state_q)
      PMSM_RUN: begin
        shields_up = 1'b0;
        d0tod3_ok  = 1'b1;
        d3tod0_ok  = cfg.pm_override | fuse.force_on;
        if (go_off | (in_d3 & ~go_on)) state_nxt = PMSM_IF_OFF;
      end
      PMSM_IF_OFF: begin
        qcnt_nxt = qcnt_q + 1'b1;
        if (qcnt_q == QCNT_LAST) begin  // Count 0..QUIESCE_CYCLES inclusive
          state_nxt = PMSM_WAIT_ACK;
          qcnt_nxt  = '0;
        end
      end
      PMSM_WAIT_ACK: begin
        pgcb_req_b = 1'b0;
        if (!rdy_ack_b_sync) state_nxt = PMSM_PWR_OFF;  // Controller gated
      end
      PMSM_PWR_OFF: begin
        pgcb_req_b = 1'b0;  // Keep gating requested
        d3tod0_ok  = 1'b1;
        if (~go_off & (~in_d3 | go_on)) state_nxt = PMSM_PWR_ON;
      end
      PMSM_PWR_ON: begin
        // Any force skips the controller handshake
        if ((idle_sync & rdy_ack_b_sync) | cfg.pm_override | fuse.force_on | hw_force_on) begin
          state_nxt = PMSM_RUN;
        end
      end
      default: state_nxt = PMSM_PWR_OFF;  // Illegal encoding recovery
    endcase
  end

  always_ff @(posedge prim_freerun_clk or negedge prim_freerun_prim_gated_rst_b_sync) begin
    if (!prim_freerun_prim_gated_rst_b_sync) begin
      state_q <= PMSM_PWR_OFF;  // Partition starts gated
      qcnt_q  <= '0;
    end else begin
      state_q <= state_nxt;
      qcnt_q  <= qcnt_nxt;
    end
  end

  // --------------------
  // Status, pulses
  // --------------------
  always_comb begin
    status.state      = state_q;
    status.shields_up = shields_up;
    status.pgcb_req_b = pgcb_req_b;
    status.d3tod0_ok  = d3tod0_ok;
    status.d0tod3_ok  = d0tod3_ok;
    status.idle_sync  = idle_sync;
  end

  assign run_entry = (state_q == PMSM_PWR_ON) && (state_nxt == PMSM_RUN);  // Last PWR_ON cycle
  assign pm_active = ~((state_q == PMSM_RUN) | (state_q == PMSM_PWR_OFF));  // In transition

endmodule

`default_nettype wire

/* verilog/pm_unit_top.sv */
// Power management unit top level
// Synchronizes the power gate controller inputs and connects the state
// machine, event counters and AXI4-Lite register block
`timescale 1ns/10ps
`default_nettype none

module pm_unit_top #(
  parameter int QUIESCE_CYCLES = 32,
  parameter int SYNC_STAGES    = 2,
  parameter int CNT_WIDTH      = 16
) (
  input  wire logic              prim_freerun_clk,
  input  wire logic              prim_freerun_prim_gated_rst_b_sync,
  input  wire pm_pkg::axil_req_t axil_req,
  output pm_pkg::axil_rsp_t      axil_rsp,
  input  wire pm_pkg::pm_fuse_t  fuse,
  input  wire logic              in_d3,
  input  wire logic              hw_force_on,
  input  wire logic              pgcb_idle,       // Async
  input  wire logic              pgcb_rdy_ack_b,  // Async, active low
  output logic                   pgcb_req_b,
  output logic                   shields_up,
  output logic                   d0tod3_ok,
  output logic                   d3tod0_ok,
  output logic                   pm_active,
  output logic                   run_entry
);

  import pm_pkg::*;

  logic [1:0] pgcb_sync;  // {rdy_ack_b, idle}
  pm_cfg_t    cfg;
  pm_status_t status;
  pm_counts_t counts;
  logic       clr_evt, clr_run;

  // Ack resets released (1), idle resets low
  pm_input_sync #(
    .WIDTH       (2),
    .SYNC_STAGES (SYNC_STAGES),
    .RESET_VALUE (2'b10)
  ) u_pgcb_sync (
    .prim_freerun_clk                   (prim_freerun_clk),
    .prim_freerun_prim_gated_rst_b_sync (prim_freerun_prim_gated_rst_b_sync),
    .async_in                           ({pgcb_rdy_ack_b, pgcb_idle}),
    .sync_out                           (pgcb_sync)
  );

  pm_state_machine #(.QUIESCE_CYCLES(QUIESCE_CYCLES)) u_pmsm (
    .prim_freerun_clk                   (prim_freerun_clk),
    .prim_freerun_prim_gated_rst_b_sync (prim_freerun_prim_gated_rst_b_sync),
    .fuse, .cfg, .in_d3, .hw_force_on,
    .idle_sync                          (pgcb_sync[0]),
    .rdy_ack_b_sync                     (pgcb_sync[1]),
    .status, .run_entry, .pm_active
  );

  pm_event_counters #(.CNT_WIDTH(CNT_WIDTH)) u_counters (
    .prim_freerun_clk                   (prim_freerun_clk),
    .prim_freerun_prim_gated_rst_b_sync (prim_freerun_prim_gated_rst_b_sync),
    .status, .run_entry, .clr_evt, .clr_run, .counts
  );

  pm_axil_regs #(.CNT_WIDTH(CNT_WIDTH)) u_regs (
    .prim_freerun_clk                   (prim_freerun_clk),
    .prim_freerun_prim_gated_rst_b_sync (prim_freerun_prim_gated_rst_b_sync),
    .axil_req, .axil_rsp, .status, .counts, .cfg, .clr_evt, .clr_run
  );

  // Board outputs straight off the status bundle
  assign pgcb_req_b = status.pgcb_req_b;
  assign shields_up = status.shields_up;
  assign d0tod3_ok  = status.d0tod3_ok;
  assign d3tod0_ok  = status.d3tod0_ok;

endmodule

`default_nettype wire
